// File: verif/poolCases.txt
identity 0
00 00 00 00 01 00 00 00 00
0000
0a fb 03 07 f8 02 00 01
04 14 fd 0f 06 ff 09 f9
fe 0b 1e fc 08 19 fa 03
05 f7 0c 12 ec 04 0e 16
00 07 ff 21 02 f1 28 06
fd 10 09 f9 1b 0b fe 05
08 f4 15 04 fb 13 0d f7
01 02 03 04 05 06 07 08
0001e 0000f 00019 0000c 00021 00028 00015 0001b 00013
signedKernel 0
ff 02 00 03 fc 01 00 fe fd
ff9c
ef e5 f8 eb dd f4 e8 f6
08 fe 11 04 f6 0d 01 0f
f9 ef 02 f5 e7 fe f2 00
12 08 1b 0e 00 17 0b 19
e5 db ee e1 d3 ea de ec
03 f9 0c ff f1 08 fc 0a
1c 12 25 18 0a 21 15 23
fe f4 07 fa ec 03 f7 05
fffc4 ffff4 fffc6 00032 00062 00034 fffbf fffef fffc1
midReset 21
00 00 00 00 01 00 00 00 00
0005
0a fb 03 07 f8 02 00 01
04 14 fd 0f 06 ff 09 f9
fe 0b 1e fc 08 19 fa 03
05 f7 0c 12 ec 04 0e 16
00 07 ff 21 02 f1 28 06
fd 10 09 f9 1b 0b fe 05
08 f4 15 04 fb 13 0d f7
01 02 03 04 05 06 07 08
00023 00014 0001e 00011 00026 0002d 0001a 00020 00018

// File: project.f
source/cnnGeomPkg.sv
source/cnnDataPkg.sv
source/lineWindow.sv
source/convMac.sv
source/maxPool.sv
source/convPoolTop.sv
verif/tbClock.sv
verif/poolChecker.sv
verif/convPoolTb.sv

// File: run.sh
#!/usr/bin/env bash
# builds and runs the convolution and pooling testbench with Verilator
set -e

cd "$(dirname "$0")"

logFile=sim.log

# compile design and testbench into one executable
verilator --binary --timing -Wno-fatal --top-module convPoolTb -f project.f -o convPoolSim

# run from the project root so the cases file is found
./obj_dir/convPoolSim | tee "$logFile"

if grep -q "Done: errors found" "$logFile"; then
    echo "simulation failed"
    exit 1
fi

if ! grep -q "Done: no errors" "$logFile"; then
    echo "simulation ended without a result"
    exit 1
fi

echo "simulation passed"

// File: verif/convPoolTb.sv
`timescale 1ns/1ps

module convPoolTb
    import cnnGeomPkg::*;
    import cnnDataPkg::*;
();

    logic         clk;
    logic         rst;
    logic         pixValid;
    pixel_t       pix;
    logic         coefWrite;
    logic [3:0]   coefAddr;
    logic [15:0]  coefData;
    logic         poolValid;
    poolBeat_t    pool;
    logic         expPush;
    acc_t         expValue;
    logic [127:0] expName;
    int           casesDone;
    int           passCount;
    int           failCount;
    int           strayCount;

    // case data, flattened per case
    logic [127:0] nameList [$];
    int           preList [$];
    coef_t        kerList [$];
    logic [15:0]  biasList [$];
    pixel_t       pixList [$];
    acc_t         expList [$];
    int           numCases;
    int           cycleLimit = 0;
    int           cycles = 0;

    tbClock clkGen (.clk(clk));

    convPoolTop uut (
        .clk       (clk),
        .rst       (rst),
        .pixValid  (pixValid),
        .pix       (pix),
        .coefWrite (coefWrite),
        .coefAddr  (coefAddr),
        .coefData  (coefData),
        .poolValid (poolValid),
        .pool      (pool)
    );

    poolChecker chk (
        .clk        (clk),
        .poolValid  (poolValid),
        .pool       (pool),
        .expPush    (expPush),
        .expValue   (expValue),
        .expName    (expName),
        .casesDone  (casesDone),
        .passCount  (passCount),
        .failCount  (failCount),
        .strayCount (strayCount)
    );

    // each case is a name line, 9 taps, bias, 64 pixels, 9 pooled values
    task automatic readCases();
        int           fd;
        int           pc;
        logic [127:0] nm;
        logic [7:0]   b8;
        logic [15:0]  b16;
        logic [19:0]  b20;
        numCases = 0;
        fd = $fopen("verif/poolCases.txt", "r");
        if (fd == 0) begin
            $display("could not open the cases file verif/poolCases.txt");
        end else begin
            while ($fscanf(fd, "%s %d", nm, pc) == 2) begin
                nameList.push_back(nm);
                preList.push_back(pc);
                for (int k = 0; k < kerTaps; k++) begin
                    void'($fscanf(fd, "%h", b8));
                    kerList.push_back(b8);
                end
                void'($fscanf(fd, "%h", b16));
                biasList.push_back(b16);
                for (int k = 0; k < imgSize * imgSize; k++) begin
                    void'($fscanf(fd, "%h", b8));
                    pixList.push_back(b8);
                end
                for (int k = 0; k < poolSize * poolSize; k++) begin
                    void'($fscanf(fd, "%h", b20));
                    expList.push_back(b20);
                end
                numCases++;
            end
            $fclose(fd);
        end
    endtask

    task automatic loadCoefs(int c);
        for (int k = 0; k <= biasAddr; k++) begin
            @(negedge clk);
            coefWrite = 1'b1;
            coefAddr = 4'(k);
            // taps go in the low byte
            coefData = (k < kerTaps) ? {8'h00, kerList[c * kerTaps + k]} : biasList[c];
        end
        @(negedge clk);
        coefWrite = 1'b0;
    endtask

    task automatic queueExpected(int c);
        for (int k = 0; k < poolSize * poolSize; k++) begin
            @(negedge clk);
            expPush = 1'b1;
            expValue = expList[c * poolSize * poolSize + k];
            expName = nameList[c];
        end
        @(negedge clk);
        expPush = 1'b0;
    endtask

    task automatic sendPixels(int c, int count, bit gaps);
        int idle;
        for (int k = 0; k < count; k++) begin
            @(negedge clk);
            pixValid = 1'b1;
            pix = pixList[c * imgSize * imgSize + k];
            idle = gaps ? int'($urandom % 4) : 0;
            repeat (idle) begin
                @(negedge clk);
                pixValid = 1'b0;
            end
        end
        @(negedge clk);
        pixValid = 1'b0;
    endtask

    task automatic applyReset();
        @(negedge clk);
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
    endtask

    // run limit, one frame at worst-case gaps plus slack per case
    always @(posedge clk) begin
        cycles++;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            $display("timeout after %0d cycles, only %0d of %0d cases got all pooled values",
                     cycles, casesDone, numCases);
            $display("cases passed %0d, failed %0d, stray outputs %0d",
                     passCount, failCount, strayCount);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        pixValid = 1'b0;
        pix = '0;
        coefWrite = 1'b0;
        coefAddr = '0;
        coefData = '0;
        expPush = 1'b0;
        expValue = '0;
        expName = '0;
        void'($urandom(59832));
        readCases();
        cycleLimit = numCases * (imgSize * imgSize * 4 + 20);

        repeat (2) @(negedge clk);
        rst = 1'b0;

        for (int c = 0; c < numCases; c++) begin
            loadCoefs(c);
            queueExpected(c);
            if (preList[c] > 0) begin
                // partial frame, thrown away by the reset
                sendPixels(c, preList[c], 1'b0);
                applyReset();
            end
            sendPixels(c, imgSize * imgSize, 1'b1);
        end

        while (casesDone < numCases) begin
            @(negedge clk);
        end
        // stray beats after the last case still get seen
        repeat (8) @(negedge clk);

        $display("cases passed %0d, failed %0d, stray outputs %0d",
                 passCount, failCount, strayCount);
        if (numCases > 0 && failCount == 0 && strayCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: verif/poolChecker.sv
`timescale 1ns/1ps

module poolChecker
    import cnnGeomPkg::*;
    import cnnDataPkg::*;
(
    input  logic         clk,
    input  logic         poolValid,
    input  poolBeat_t    pool,
    input  logic         expPush,
    input  acc_t         expValue,
    input  logic [127:0] expName,
    output int           casesDone,
    output int           passCount,
    output int           failCount,
    output int           strayCount
);

    // expected values in output order, each tagged with its case name
    acc_t         expQ [$];
    logic [127:0] nameQ [$];

    int           beat;
    int           caseErrors;
    acc_t         want;
    logic [127:0] curName;

    initial begin
        casesDone = 0;
        passCount = 0;
        failCount = 0;
        strayCount = 0;
        beat = 0;
        caseErrors = 0;
    end

    always @(posedge clk) begin
        if (expPush) begin
            expQ.push_back(expValue);
            nameQ.push_back(expName);
        end

        if (poolValid) begin
            if (expQ.size() == 0) begin
                $display("pool output %h arrived while no case was waiting for one", pool.value);
                strayCount++;
            end else begin
                want = expQ.pop_front();
                curName = nameQ.pop_front();
                if (pool.value !== want) begin
                    $display("error: pool.value got %h expected %h (case %0s, beat %0d)",
                             pool.value, want, curName, beat);
                    caseErrors++;
                end

                // frame marker belongs on the ninth beat only
                if (beat == poolSize * poolSize - 1) begin
                    if (pool.lastInFrame !== 1'b1) begin
                        $display("case %0s: lastInFrame missing on the last pooled value",
                                 curName);
                        caseErrors++;
                    end
                end else if (pool.lastInFrame !== 1'b0) begin
                    $display("case %0s: lastInFrame set early on pooled value %0d",
                             curName, beat);
                    caseErrors++;
                end

                if (beat == poolSize * poolSize - 1) begin
                    if (caseErrors == 0) begin
                        $display("case %0s: pass", curName);
                        passCount++;
                    end else begin
                        $display("case %0s: fail with %0d errors", curName, caseErrors);
                        failCount++;
                    end
                    casesDone++;
                    beat = 0;
                    caseErrors = 0;
                end else begin
                    beat++;
                end
            end
        end
    end

endmodule

// File: verif/tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic clk
);

    // 4 ns period, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

endmodule

// File: source/convPoolTop.sv
`timescale 1ns/1ps

module convPoolTop
    import cnnDataPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        pixValid,
    input  pixel_t      pix,
    input  logic        coefWrite,
    input  logic [3:0]  coefAddr,
    input  logic [15:0] coefData,
    output logic        poolValid,
    output poolBeat_t   pool
);

    // window former to MAC
    logic    winValid;
    window_t win;
    mapPos_t winPos;

    // MAC to pooling
    logic      convValid;
    convBeat_t conv;

    lineWindow uLineWindow (
        .clk      (clk),
        .rst      (rst),
        .pixValid (pixValid),
        .pix      (pix),
        .winValid (winValid),
        .win      (win),
        .winPos   (winPos)
    );

    convMac uConvMac (
        .clk       (clk),
        .rst       (rst),
        .coefWrite (coefWrite),
        .coefAddr  (coefAddr),
        .coefData  (coefData),
        .winValid  (winValid),
        .win       (win),
        .winPos    (winPos),
        .convValid (convValid),
        .conv      (conv)
    );

    maxPool uMaxPool (
        .clk       (clk),
        .rst       (rst),
        .convValid (convValid),
        .conv      (conv),
        .poolValid (poolValid),
        .pool      (pool)
    );

endmodule

// File: source/maxPool.sv
`timescale 1ns/1ps

module maxPool
    import cnnGeomPkg::*;
    import cnnDataPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      convValid,
    input  convBeat_t conv,
    output logic      poolValid,
    output poolBeat_t pool
);

    typedef logic [$clog2(poolSize)-1:0] poolIdx_t;

    // column-pair maxima from the first row of each pooling block
    acc_t partial [poolSize];

    // first value of the current column pair
    acc_t pairHold;

    acc_t     pairBest;
    poolIdx_t pairIdx;
    logic     pairRowEnd;
    logic     pairColEnd;

    function automatic acc_t maxOf(acc_t a, acc_t b);
        // signed compare
        return (a > b) ? a : b;
    endfunction

    always_comb begin
        pairRowEnd = (int'(conv.pos.row) % poolStep) == poolStep - 1;
        pairColEnd = (int'(conv.pos.col) % poolStep) == poolStep - 1;
        pairIdx = poolIdx_t'(int'(conv.pos.col) / poolStep);
        pairBest = maxOf(pairHold, conv.value);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            poolValid <= 1'b0;
        end else begin
            // fires on the last beat of each 2x2 block
            poolValid <= convValid && pairRowEnd && pairColEnd;
        end
    end

    always_ff @(posedge clk) begin
        if (convValid) begin
            if (!pairColEnd) begin
                pairHold <= conv.value;
            end else if (!pairRowEnd) begin
                partial[pairIdx] <= pairBest;
            end else begin
                // merge with the stored upper pair
                pool.value <= maxOf(pairBest, partial[pairIdx]);
                pool.lastInFrame <= conv.pos.lastInFrame;
            end
        end
    end

endmodule

// File: source/convMac.sv
`timescale 1ns/1ps

module convMac
    import cnnGeomPkg::*;
    import cnnDataPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        coefWrite,
    input  logic [3:0]  coefAddr,
    input  logic [15:0] coefData,
    input  logic        winValid,
    input  window_t     win,
    input  mapPos_t     winPos,
    output logic        convValid,
    output convBeat_t   conv
);

    typedef logic signed [pixW+coefW-1:0] prod_t;

    // kernel taps in window order, plus bias
    coef_t kernel [kerTaps];
    logic signed [biasW-1:0] bias;

    // products stage
    prod_t   prod [kerTaps];
    logic    prodValid;
    mapPos_t prodPos;

    acc_t sum;

    // coefficient writes by address
    always_ff @(posedge clk) begin
        if (coefWrite) begin
            for (int k = 0; k < kerTaps; k++) begin
                if (coefAddr == 4'(k)) begin
                    // taps take the low byte
                    kernel[k] <= coefData[coefW-1:0];
                end
            end
            if (coefAddr == 4'(biasAddr)) begin
                bias <= coefData;
            end
        end
    end

    // stage 1, nine signed products
    always_ff @(posedge clk) begin
        if (rst) begin
            prodValid <= 1'b0;
        end else begin
            prodValid <= winValid;
        end
    end

    always_ff @(posedge clk) begin
        if (winValid) begin
            for (int k = 0; k < kerTaps; k++) begin
                prod[k] <= win[k] * kernel[k];
            end
            prodPos <= winPos;
        end
    end

    // adder tree with bias, everything sign extended to acc width
    always_comb begin
        sum = acc_t'(bias);
        for (int k = 0; k < kerTaps; k++) begin
            sum = sum + acc_t'(prod[k]);
        end
    end

    // stage 2
    always_ff @(posedge clk) begin
        if (rst) begin
            convValid <= 1'b0;
        end else begin
            convValid <= prodValid;
        end
    end

    always_ff @(posedge clk) begin
        if (prodValid) begin
            conv.value <= sum;
            conv.pos <= prodPos;
        end
    end

endmodule

// File: source/lineWindow.sv
`timescale 1ns/1ps

module lineWindow
    import cnnGeomPkg::*;
    import cnnDataPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    pixValid,
    input  pixel_t  pix,
    output logic    winValid,
    output window_t win,
    output mapPos_t winPos
);

    typedef logic [$clog2(imgSize)-1:0] imgIdx_t;

    // the two previous image rows, indexed by column
    pixel_t rowBufNear [imgSize];
    pixel_t rowBufFar  [imgSize];

    // raster position of the incoming pixel
    imgIdx_t row;
    imgIdx_t col;

    // column entering the window, top to bottom
    pixel_t  newCol [kerSize];
    logic    fullWin;
    mapPos_t nextPos;

    always_comb begin
        newCol[0] = rowBufFar[col];
        newCol[1] = rowBufNear[col];
        newCol[2] = pix;

        fullWin = (row >= imgIdx_t'(kerSize - 1)) && (col >= imgIdx_t'(kerSize - 1));

        // window anchor is the top-left corner
        nextPos.row = posW'(row - imgIdx_t'(kerSize - 1));
        nextPos.col = posW'(col - imgIdx_t'(kerSize - 1));
        nextPos.lastInFrame = (nextPos.row == posW'(convSize - 1)) &&
                              (nextPos.col == posW'(convSize - 1));
    end

    // position counters, wrap after the last pixel of a frame
    always_ff @(posedge clk) begin
        if (rst) begin
            row <= '0;
            col <= '0;
            winValid <= 1'b0;
        end else begin
            winValid <= pixValid && fullWin;
            if (pixValid) begin
                if (col == imgIdx_t'(imgSize - 1)) begin
                    col <= '0;
                    if (row == imgIdx_t'(imgSize - 1)) begin
                        row <= '0;
                    end else begin
                        row <= row + 1'b1;
                    end
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    // row buffers and window shift
    always_ff @(posedge clk) begin
        if (pixValid) begin
            // age the column by one row
            rowBufFar[col] <= rowBufNear[col];
            rowBufNear[col] <= pix;

            for (int k = 0; k < kerSize; k++) begin
                for (int j = 0; j < kerSize - 1; j++) begin
                    win[k * kerSize + j] <= win[k * kerSize + j + 1];
                end
                win[k * kerSize + kerSize - 1] <= newCol[k];
            end

            // only meaningful together with winValid
            winPos <= nextPos;
        end
    end

endmodule

// File: source/cnnDataPkg.sv
package cnnDataPkg;

    import cnnGeomPkg::*;

    // datapath widths
    localparam int pixW = 8;
    localparam int coefW = 8;
    localparam int biasW = 16;
    localparam int accW = 20;

    // map row and column index width
    localparam int posW = $clog2(convSize);

    typedef logic signed [pixW-1:0] pixel_t;
    typedef logic signed [coefW-1:0] coef_t;
    typedef logic signed [accW-1:0] acc_t;

    // index 0 is the top-left pixel, raster order after that
    typedef pixel_t [kerTaps-1:0] window_t;

    typedef struct packed {
        logic [posW-1:0] row;
        logic [posW-1:0] col;
        logic            lastInFrame;
    } mapPos_t;

    typedef struct packed {
        acc_t    value;
        mapPos_t pos;
    } convBeat_t;

    typedef struct packed {
        acc_t value;
        logic lastInFrame;
    } poolBeat_t;

endpackage

// File: source/cnnGeomPkg.sv
package cnnGeomPkg;

    // input image side
    localparam int imgSize = 8;

    // convolution kernel side and tap count
    localparam int kerSize = 3;
    localparam int kerTaps = kerSize * kerSize;

    // valid convolution only, no padding
    localparam int convSize = imgSize - kerSize + 1;

    // pooling window side, equal to its stride
    localparam int poolStep = 2;
    localparam int poolSize = convSize / poolStep;

    // bias sits right after the last tap in the coefficient space
    localparam int biasAddr = kerTaps;

endpackage
